//--- include/frontend_defs.svh
`ifndef FRONTEND_DEFS_SVH
`define FRONTEND_DEFS_SVH

// First fetch address after reset
`define FRONTEND_RESET_PC 32'h1C00_0000

// Instruction buffer entries, power of two
`define FRONTEND_IB_DEPTH 8

`endif

//--- source/pipeline_types.sv
package pipeline_types;

`include "frontend_defs.svh"

    //////////////////////////////////////////////////////////////////////
    // Sizes and constants
    //////////////////////////////////////////////////////////////////////
    localparam logic [31:0] RESET_PC = `FRONTEND_RESET_PC;
    localparam int IB_DEPTH = `FRONTEND_IB_DEPTH;
    // Two spare entries absorb the responses still in flight
    localparam int IB_STALL_LEVEL = IB_DEPTH - 2;
    localparam int IB_PTR_W = $clog2(IB_DEPTH);
    localparam int BHT_ENTRIES = 16;
    localparam int BHT_IDX_W = $clog2(BHT_ENTRIES);
    localparam logic [1:0] BHT_INIT = 2'd1;
    localparam logic [1:0] BHT_TAKEN_MIN = 2'd2;

    //////////////////////////////////////////////////////////////////////
    // Encodings
    //////////////////////////////////////////////////////////////////////
    typedef enum logic [5:0] {
        OP_ALU   = 6'h00,
        OP_JUMP  = 6'h02,
        OP_BCOND = 6'h04
    } inst_op_e;

    typedef enum logic [1:0] {
        CTRL_NONE      = 2'd0,
        CTRL_HOLD      = 2'd1,
        CTRL_EXCEPTION = 2'd2
    } ctrl_e;

    //////////////////////////////////////////////////////////////////////
    // Bundles
    //////////////////////////////////////////////////////////////////////
    typedef struct packed {
        logic        is_branch;
        logic        taken;
        logic [31:0] target;
    } pred_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic        taken;
        logic        branch_flush;
        logic [31:0] branch_actual_addr;
    } branch_update_t;

    typedef struct packed {
        logic [31:0] inst;
        logic [31:0] pc;
        logic        is_exception;
        pred_t       pred;
    } inst_and_pc_t;

    typedef struct packed {
        logic        inst_en;
        logic [31:0] pc;
        logic        front_is_exception;
    } fetch_req_t;

    typedef struct packed {
        logic        is_valid;
        logic [31:0] inst;
        logic [31:0] pc;
        logic        is_exception;
    } fetch_rsp_t;

    // Mispredict flush reported by the back end
    function automatic logic is_flush(branch_update_t upd);
        return upd.valid && upd.branch_flush;
    endfunction

endpackage

//--- source/pc_reg.sv
module pc_reg
    import pipeline_types::*;
(
    input  logic           clk,
    input  logic           arst_n,
    input  logic           buffer_stall,
    input  pred_t          pred,
    input  logic           rsp_valid,
    input  branch_update_t update_info,
    input  ctrl_e          ctrl,
    input  logic [31:0]    ctrl_pc,
    output fetch_req_t     fetch_req
);

    logic [31:0] pc_q;
    logic [31:0] pc_d;
    logic        running_q;
    logic        parked_q;
    logic        drop_rsp_q;
    logic        flush;
    logic        exception;
    logic        pred_redirect;
    logic        misaligned;
    logic        issue;

    assign flush     = is_flush(update_info);
    assign exception = (ctrl == CTRL_EXCEPTION);
    // Response right after any redirect belongs to the old path
    assign pred_redirect = rsp_valid && pred.taken && !drop_rsp_q;
    assign misaligned    = (pc_q[1:0] != 2'b00);
    assign issue = running_q && !parked_q && !buffer_stall && (ctrl != CTRL_HOLD);

    // Next fetch address, highest priority first
    always_comb begin
        pc_d = pc_q;
        if (flush) begin
            pc_d = update_info.branch_actual_addr;
        end else if (exception) begin
            pc_d = ctrl_pc;
        end else if (pred_redirect) begin
            pc_d = pred.target;
        end else if (issue) begin
            pc_d = pc_q + 32'd4;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc_q       <= RESET_PC;
            running_q  <= 1'b0;
            parked_q   <= 1'b0;
            drop_rsp_q <= 1'b0;
        end else begin
            pc_q       <= pc_d;
            running_q  <= 1'b1;
            drop_rsp_q <= flush || exception || pred_redirect;
            // Park after a bad address until the back end steers us away
            if (flush || exception) begin
                parked_q <= 1'b0;
            end else if (issue && misaligned) begin
                parked_q <= 1'b1;
            end
        end
    end

    assign fetch_req.inst_en            = issue;
    assign fetch_req.pc                 = pc_q;
    assign fetch_req.front_is_exception = misaligned;

    a_no_fetch_in_hold: assert property (@(posedge clk) disable iff (!arst_n)
        (ctrl == CTRL_HOLD) |-> !fetch_req.inst_en);

endmodule

//--- source/bpu.sv
module bpu
    import pipeline_types::*;
(
    input  logic           clk,
    input  logic           arst_n,
    input  fetch_rsp_t     rsp,
    input  branch_update_t update_info,
    output pred_t          pred
);

    logic [1:0]           bht_q [BHT_ENTRIES];
    inst_op_e             op;
    logic [31:0]          offset_bytes;
    logic [BHT_IDX_W-1:0] rd_idx;
    logic [BHT_IDX_W-1:0] wr_idx;
    logic                 decode_en;

    //////////////////////////////////////////////////////////////////////
    // Decode and target
    //////////////////////////////////////////////////////////////////////
    // Faulted fetches carry no usable instruction
    assign decode_en = rsp.is_valid && !rsp.is_exception;
    assign op        = inst_op_e'(rsp.inst[31:26]);
    // Signed word offset scaled to bytes
    assign offset_bytes = {{14{rsp.inst[15]}}, rsp.inst[15:0], 2'b00};
    assign rd_idx = rsp.pc[BHT_IDX_W+1:2];
    assign wr_idx = update_info.pc[BHT_IDX_W+1:2];

    always_comb begin
        pred.is_branch = 1'b0;
        pred.taken     = 1'b0;
        pred.target    = rsp.pc + offset_bytes;
        if (decode_en) begin
            case (op)
                OP_JUMP: begin
                    pred.is_branch = 1'b1;
                    pred.taken     = 1'b1;
                end
                OP_BCOND: begin
                    pred.is_branch = 1'b1;
                    pred.taken     = (bht_q[rd_idx] >= BHT_TAKEN_MIN);
                end
                default: begin
                    pred.is_branch = 1'b0;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // 2-bit counters, trained by the back end
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < BHT_ENTRIES; i++) begin
                bht_q[i] <= BHT_INIT;
            end
        end else if (update_info.valid) begin
            if (update_info.taken && bht_q[wr_idx] != 2'b11) begin
                bht_q[wr_idx] <= bht_q[wr_idx] + 2'd1;
            end else if (!update_info.taken && bht_q[wr_idx] != 2'b00) begin
                bht_q[wr_idx] <= bht_q[wr_idx] - 2'd1;
            end
        end
    end

    a_taken_is_branch: assert property (@(posedge clk) disable iff (!arst_n)
        pred.taken |-> pred.is_branch && rsp.is_valid);

endmodule

//--- source/instbuffer.sv
module instbuffer
    import pipeline_types::*;
(
    input  logic           clk,
    input  logic           arst_n,
    input  fetch_rsp_t     rsp,
    input  pred_t          pred,
    input  branch_update_t update_info,
    input  ctrl_e          ctrl,
    input  logic [31:0]    ctrl_pc,
    input  logic           send_inst_en,
    output logic           buffer_stall,
    output inst_and_pc_t   inst_and_pc_o,
    output logic           inst_valid
);

    inst_and_pc_t        mem [IB_DEPTH];
    logic [IB_PTR_W-1:0] wr_ptr_q;
    logic [IB_PTR_W-1:0] rd_ptr_q;
    logic [IB_PTR_W:0]   count_q;
    logic [31:0]         expect_pc_q;
    logic                flush;
    logic                exception;
    logic                redirect;
    logic                push;
    logic                pop;
    inst_and_pc_t        new_entry;

    assign flush     = is_flush(update_info);
    assign exception = (ctrl == CTRL_EXCEPTION);
    assign redirect  = flush || exception;

    //////////////////////////////////////////////////////////////////////
    // Wrong-path filter
    //////////////////////////////////////////////////////////////////////
    // Only the next pc in program order gets in
    assign push = rsp.is_valid && (rsp.pc == expect_pc_q) && !redirect;
    assign pop  = send_inst_en && inst_valid;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            expect_pc_q <= RESET_PC;
        end else if (flush) begin
            expect_pc_q <= update_info.branch_actual_addr;
        end else if (exception) begin
            expect_pc_q <= ctrl_pc;
        end else if (push) begin
            expect_pc_q <= pred.taken ? pred.target : rsp.pc + 32'd4;
        end
    end

    assign new_entry.inst         = rsp.inst;
    assign new_entry.pc           = rsp.pc;
    assign new_entry.is_exception = rsp.is_exception;
    assign new_entry.pred         = pred;

    //////////////////////////////////////////////////////////////////////
    // Circular FIFO
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (redirect) begin
            // Everything queued is on the old path
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + IB_PTR_W'(1);
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + IB_PTR_W'(1);
            end
            if (push && !pop) begin
                count_q <= count_q + (IB_PTR_W + 1)'(1);
            end else if (!push && pop) begin
                count_q <= count_q - (IB_PTR_W + 1)'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr_q] <= new_entry;
        end
    end

    assign inst_valid    = (count_q != '0);
    assign inst_and_pc_o = mem[rd_ptr_q];
    assign buffer_stall  = (count_q >= (IB_PTR_W + 1)'(IB_STALL_LEVEL));

    // Stall threshold must leave room for in-flight responses
    a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
        push && !pop |-> count_q < (IB_PTR_W + 1)'(IB_DEPTH));

    // Reads never run past what was written
    a_no_underflow: assert property (@(posedge clk) disable iff (!arst_n)
        (count_q == '0) |-> (rd_ptr_q == wr_ptr_q));

endmodule

//--- source/frontend_top.sv
module frontend_top
    import pipeline_types::*;
(
    input  logic           clk,
    input  logic           arst_n,

    // Instruction cache
    output fetch_req_t     fetch_req,
    input  fetch_rsp_t     fetch_rsp,

    // Back end
    input  branch_update_t update_info,
    input  ctrl_e          ctrl,
    input  logic [31:0]    ctrl_pc,
    input  logic           send_inst_en,
    output inst_and_pc_t   inst_and_pc_o,
    output logic           inst_valid
);

    pred_t pred;
    logic  buffer_stall;

    pc_reg u_pc_reg (
        .clk          (clk),
        .arst_n       (arst_n),
        .buffer_stall (buffer_stall),
        .pred         (pred),
        .rsp_valid    (fetch_rsp.is_valid),
        .update_info  (update_info),
        .ctrl         (ctrl),
        .ctrl_pc      (ctrl_pc),
        .fetch_req    (fetch_req)
    );

    // Prediction comes straight off the cache response
    bpu u_bpu (
        .clk         (clk),
        .arst_n      (arst_n),
        .rsp         (fetch_rsp),
        .update_info (update_info),
        .pred        (pred)
    );

    instbuffer u_instbuffer (
        .clk           (clk),
        .arst_n        (arst_n),
        .rsp           (fetch_rsp),
        .pred          (pred),
        .update_info   (update_info),
        .ctrl          (ctrl),
        .ctrl_pc       (ctrl_pc),
        .send_inst_en  (send_inst_en),
        .buffer_stall  (buffer_stall),
        .inst_and_pc_o (inst_and_pc_o),
        .inst_valid    (inst_valid)
    );

endmodule

//--- dv/icache_model.sv
module icache_model
    import pipeline_types::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  fetch_req_t fetch_req,
    output fetch_rsp_t fetch_rsp
);

    timeunit 1ns;
    timeprecision 1ps;

    fetch_rsp_t rsp_q = '0;

    //////////////////////////////////////////////////////////////////////
    // Instruction image, a pure function of the address
    //////////////////////////////////////////////////////////////////////
    // Word slot 4 branches forward, slot 9 branches back, slot 12 jumps
    function automatic logic [31:0] inst_at(input logic [31:0] addr);
        logic [25:0] payload;
        payload = addr[27:2] ^ {20'd0, addr[31:28], addr[1:0]};
        case (addr[5:2])
            4'd4:    return {OP_BCOND, addr[11:2], 16'h0003};
            4'd9:    return {OP_BCOND, addr[11:2], 16'hFFF9};
            4'd12:   return {OP_JUMP, addr[11:2], 16'h0006};
            default: return {OP_ALU, payload};
        endcase
    endfunction

    // One cycle of latency, every request answered
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rsp_q <= '0;
        end else begin
            rsp_q.is_valid     <= fetch_req.inst_en;
            rsp_q.inst         <= inst_at(fetch_req.pc);
            rsp_q.pc           <= fetch_req.pc;
            rsp_q.is_exception <= fetch_req.front_is_exception;
        end
    end

    assign fetch_rsp = rsp_q;

endmodule

//--- dv/tb_frontend_top.sv
module tb_frontend_top
    import pipeline_types::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    // The phases below need well under 1000 cycles
    localparam int MAX_CYCLES = 4000;

    logic           clk;
    logic           arst_n;
    fetch_req_t     fetch_req;
    fetch_rsp_t     fetch_rsp;
    branch_update_t update_info;
    ctrl_e          ctrl;
    logic [31:0]    ctrl_pc;
    logic           send_inst_en;
    inst_and_pc_t   inst_and_pc_o;
    logic           inst_valid;

    int          seed;
    int          errors = 0;
    int          pops = 0;
    int          cycle_count = 0;
    logic [31:0] ref_pc;
    logic [1:0]  ref_bht [16];

    frontend_top i_frontend_top (
        .clk           (clk),
        .arst_n        (arst_n),
        .fetch_req     (fetch_req),
        .fetch_rsp     (fetch_rsp),
        .update_info   (update_info),
        .ctrl          (ctrl),
        .ctrl_pc       (ctrl_pc),
        .send_inst_en  (send_inst_en),
        .inst_and_pc_o (inst_and_pc_o),
        .inst_valid    (inst_valid)
    );

    icache_model i_icache_model (
        .clk       (clk),
        .arst_n    (arst_n),
        .fetch_req (fetch_req),
        .fetch_rsp (fetch_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin
        wait (cycle_count >= MAX_CYCLES);
        $display("Timeout: run still busy after %0d cycles", MAX_CYCLES);
        $display("Errors: %0d, entries checked: %0d", errors, pops);
        $display("Test failures found");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////
    function automatic logic [31:0] expected_inst(input logic [31:0] addr);
        logic [25:0] payload;
        payload = addr[27:2] ^ {20'd0, addr[31:28], addr[1:0]};
        if (addr[5:2] == 4'd4) begin
            return {OP_BCOND, addr[11:2], 16'h0003};
        end else if (addr[5:2] == 4'd9) begin
            return {OP_BCOND, addr[11:2], 16'hFFF9};
        end else if (addr[5:2] == 4'd12) begin
            return {OP_JUMP, addr[11:2], 16'h0006};
        end
        return {OP_ALU, payload};
    endfunction

    // Prediction for the instruction at pc, given its 2-bit counter
    function automatic pred_t predict(input logic [31:0] pc, input logic [1:0] counter);
        pred_t       p;
        logic [31:0] inst;
        logic [31:0] offset;
        inst        = expected_inst(pc);
        offset      = 32'($signed(inst[15:0]));
        p.is_branch = 1'b0;
        p.taken     = 1'b0;
        p.target    = pc + (offset << 2);
        // Misaligned fetch is a fault, never a branch
        if (pc[1:0] == 2'b00) begin
            if (inst[31:26] == OP_JUMP) begin
                p.is_branch = 1'b1;
                p.taken     = 1'b1;
            end else if (inst[31:26] == OP_BCOND) begin
                p.is_branch = 1'b1;
                p.taken     = (counter >= 2'd2);
            end
        end
        return p;
    endfunction

    task automatic train_reference(input logic [31:0] pc, input logic taken);
        if (taken && ref_bht[pc[5:2]] != 2'd3) begin
            ref_bht[pc[5:2]] = ref_bht[pc[5:2]] + 2'd1;
        end else if (!taken && ref_bht[pc[5:2]] != 2'd0) begin
            ref_bht[pc[5:2]] = ref_bht[pc[5:2]] - 2'd1;
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_entry(input inst_and_pc_t entry);
        pred_t exp_pred;
        exp_pred = predict(ref_pc, ref_bht[ref_pc[5:2]]);
        check_value("inst_and_pc_o.pc", entry.pc, ref_pc);
        check_value("inst_and_pc_o.inst", entry.inst, expected_inst(ref_pc));
        check_value("inst_and_pc_o.is_exception", 32'(entry.is_exception),
                    32'(ref_pc[1:0] != 2'b00));
        check_value("inst_and_pc_o.pred.is_branch", 32'(entry.pred.is_branch),
                    32'(exp_pred.is_branch));
        check_value("inst_and_pc_o.pred.taken", 32'(entry.pred.taken), 32'(exp_pred.taken));
        if (exp_pred.is_branch) begin
            check_value("inst_and_pc_o.pred.target", entry.pred.target, exp_pred.target);
        end
        ref_pc = exp_pred.taken ? exp_pred.target : ref_pc + 32'd4;
        pops++;
    endtask

    // Inputs are stable at the falling edge, so compare there
    always @(negedge clk) begin
        if (!arst_n) begin
            ref_pc = RESET_PC;
            for (int i = 0; i < 16; i++) begin
                ref_bht[i] = 2'd1;
            end
        end else begin
            if (send_inst_en && inst_valid) begin
                check_entry(inst_and_pc_o);
            end
            if (update_info.valid) begin
                train_reference(update_info.pc, update_info.taken);
            end
            if (update_info.valid && update_info.branch_flush) begin
                ref_pc = update_info.branch_actual_addr;
            end else if (ctrl == CTRL_EXCEPTION) begin
                ref_pc = ctrl_pc;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Back-end stimulus
    //////////////////////////////////////////////////////////////////////
    task automatic after_edge();
        @(posedge clk);
        #5;
    endtask

    // Pop at random until the given number of entries went out
    task automatic pop_until(input int count);
        int target;
        target = pops + count;
        while (pops < target) begin
            send_inst_en = (($random(seed) & 3) != 0);
            after_edge();
        end
        send_inst_en = 1'b0;
    endtask

    task automatic send_update(input logic [31:0] pc, input logic taken,
                               input logic flush, input logic [31:0] addr);
        send_inst_en                   = 1'b0;
        update_info.valid              = 1'b1;
        update_info.pc                 = pc;
        update_info.taken              = taken;
        update_info.branch_flush       = flush;
        update_info.branch_actual_addr = addr;
        after_edge();
        update_info = '0;
    endtask

    task automatic raise_exception(input logic [31:0] addr);
        send_inst_en = 1'b0;
        ctrl         = CTRL_EXCEPTION;
        ctrl_pc      = addr;
        after_edge();
        ctrl = CTRL_NONE;
    endtask

    initial begin
        int start_pops;
        arst_n       = 1'b0;
        update_info  = '0;
        ctrl         = CTRL_NONE;
        ctrl_pc      = '0;
        send_inst_en = 1'b0;
        seed         = 83116;
        repeat (16) @(posedge clk);
        #5;
        arst_n = 1'b1;

        // One idle cycle, then fetch from the reset vector
        check_value("fetch_req.inst_en", 32'(fetch_req.inst_en), 32'd0);
        check_value("inst_valid", 32'(inst_valid), 32'd0);
        after_edge();
        check_value("fetch_req.inst_en", 32'(fetch_req.inst_en), 32'd1);
        check_value("fetch_req.pc", fetch_req.pc, RESET_PC);
        pop_until(24);

        // Full buffer, then drain
        repeat (30) after_edge();
        pop_until(20);
        ctrl = CTRL_HOLD;
        repeat (10) begin
            send_inst_en = (($random(seed) & 3) != 0);
            after_edge();
        end
        ctrl = CTRL_NONE;
        pop_until(10);

        // Train both branch slots taken, then restart from the reset vector
        send_update(RESET_PC + 32'h24, 1'b1, 1'b0, '0);
        send_update(RESET_PC + 32'h24, 1'b1, 1'b0, '0);
        send_update(RESET_PC + 32'h10, 1'b1, 1'b0, '0);
        send_update(RESET_PC + 32'h24, 1'b1, 1'b1, RESET_PC);
        pop_until(30);

        // Flush with a full buffer
        repeat (5) after_edge();
        send_update(RESET_PC + 32'h4, 1'b0, 1'b1, RESET_PC + 32'h404);
        pop_until(20);

        // Untrain, then exception redirects
        repeat (3) send_update(RESET_PC + 32'h24, 1'b0, 1'b0, '0);
        repeat (2) send_update(RESET_PC + 32'h10, 1'b0, 1'b0, '0);
        raise_exception(RESET_PC + 32'h200);
        pop_until(25);

        raise_exception(RESET_PC + 32'h302);
        start_pops   = pops;
        send_inst_en = 1'b1;
        repeat (40) after_edge();
        send_inst_en = 1'b0;
        assert (pops - start_pops == 1) else begin
            $display("Misaligned redirect gave %0d entries instead of one", pops - start_pops);
            errors++;
        end

        // Fetch picks up again after a flush
        send_update(RESET_PC, 1'b0, 1'b1, RESET_PC);
        pop_until(10);

        $display("Errors: %0d, entries checked: %0d", errors, pops);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- frontend_top.f
+incdir+include
source/pipeline_types.sv
source/pc_reg.sv
source/bpu.sv
source/instbuffer.sv
source/frontend_top.sv
dv/icache_model.sv
dv/tb_frontend_top.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_frontend_top
RTL_TOP    := frontend_top
FILELIST   := frontend_top.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
PASS_MSG   := All tests passed!

.PHONY: all lint sim clean

all: sim

# Lint the design and the testbench sources
lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# Build, run, and fail unless the pass message shows up
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
